/* common/core_pkg.sv */
/*
 * shared core definitions
 *   option word width, field positions and field codes
 *   rv32i opcodes and the ebreak word
 *   memory sizes and reset pc
 *   instruction word views by format
 */
`default_nettype none

package core_pkg;

    // option word layout
    localparam int opt_w      = 16;
    localparam int opt_wen    = 0;
    localparam int opt_ren_lo = 1;
    localparam int opt_ren_hi = 2;
    localparam int opt_arg_lo = 3;
    localparam int opt_arg_hi = 4;
    localparam int opt_alu_lo = 5;
    localparam int opt_alu_hi = 7;
    localparam int opt_pc_lo  = 8;
    localparam int opt_pc_hi  = 9;
    localparam int opt_mem_lo = 10;
    localparam int opt_mem_hi = 12;
    localparam int opt_shamt  = 13;
    localparam int opt_uns    = 14;
    localparam int opt_halt   = 15;

    // alu operand pairs
    localparam logic [1:0] arg_zero_imm = 2'b00;
    localparam logic [1:0] arg_pc_imm   = 2'b01;
    localparam logic [1:0] arg_rs1_rs2  = 2'b10;
    localparam logic [1:0] arg_rs1_imm  = 2'b11;

    // alu functions, shr is arithmetic unless opt_uns
    localparam logic [2:0] alu_none = 3'b000;
    localparam logic [2:0] alu_add  = 3'b001;
    localparam logic [2:0] alu_and  = 3'b010;
    localparam logic [2:0] alu_or   = 3'b011;
    localparam logic [2:0] alu_xor  = 3'b100;
    localparam logic [2:0] alu_shl  = 3'b101;
    localparam logic [2:0] alu_shr  = 3'b110;
    localparam logic [2:0] alu_link = 3'b111;

    // next pc; zero code is sequential so an empty word falls through
    localparam logic [1:0] pc_seq  = 2'b00;
    localparam logic [1:0] pc_hold = 2'b01;
    localparam logic [1:0] pc_rel  = 2'b10;
    localparam logic [1:0] pc_reg  = 2'b11;

    // memory ops, loads have the top bit set
    localparam logic [2:0] mem_none = 3'b000;
    localparam logic [2:0] mem_sb   = 3'b001;
    localparam logic [2:0] mem_sh   = 3'b010;
    localparam logic [2:0] mem_sw   = 3'b011;
    localparam logic [2:0] mem_lb   = 3'b101;
    localparam logic [2:0] mem_lh   = 3'b110;
    localparam logic [2:0] mem_lw   = 3'b111;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;
    localparam logic [31:0] ebreak_word = 32'h0010_0073;

    localparam logic [31:0] reset_pc = 32'h8000_0000;
    // word address bits of instruction ram, byte address bits of data ram
    localparam int imem_aw = 8;
    localparam int dmem_aw = 10;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_t;

endpackage

`default_nettype wire

/* fetch/fetch_unit.sv */
/*
 * fetch stage
 *   pc register and next pc load
 *   instruction ram with program load port
 *   sticky halt latch
 */
`default_nettype none

module fetch_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        prog_we,
    input  logic [core_pkg::imem_aw-1:0] prog_addr,
    input  logic [31:0]                 prog_data,
    input  logic [31:0]                 dnpc,
    input  logic                        halt_req,
    output logic [31:0]                 pc,
    output logic [31:0]                 inst,
    output logic                        halted
);

    localparam int top_lo = core_pkg::imem_aw + 2;

    logic [31:0] imem [2**core_pkg::imem_aw];
    logic        halt_q;

    // program load from outside
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // pc only advances while running
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= core_pkg::reset_pc;
            halt_q <= 1'b0;
        end else begin
            if (!halt_q) begin
                pc <= dnpc;
            end
            // ebreak seen in decode
            if (halt_req) begin
                halt_q <= 1'b1;
            end
        end
    end

    // word index drops the byte offset
    assign inst = imem[pc[top_lo-1:2]];

    // reported high in reset too, so writeback and stores stay quiet
    assign halted = halt_q | ~rst_n;

    // program is only loaded while the core is held in reset
    a_load_in_reset: assert property (@(posedge clk) prog_we |-> !rst_n);

    a_pc_window: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00 && pc[31:top_lo] == core_pkg::reset_pc[31:top_lo]);

endmodule

`default_nettype wire

/* decode/inst_decoder.sv */
/*
 * instruction decoder
 *   register indices from fixed fields
 *   immediate by format
 *   option word by opcode and funct3/funct7
 */
`default_nettype none

module inst_decoder (
    input  logic [31:0]               inst,
    output logic [4:0]                rs1,
    output logic [4:0]                rs2,
    output logic [4:0]                rd,
    output logic [31:0]               imm,
    output logic [core_pkg::opt_w-1:0] opt
);

    core_pkg::inst_t iw;
    logic [31:0] imm_i, imm_s, imm_u, imm_j;
    logic [2:0]  f3;
    logic [6:0]  f7;
    // option fields before packing
    logic        valid, wen, shamt, uns, halt;
    logic [1:0]  ren, arg, pcs;
    logic [2:0]  alu, mem;

    assign iw  = inst;
    assign f3  = iw.r_fmt.funct3;
    assign f7  = iw.r_fmt.funct7;
    // register fields sit in the same place in every format
    assign rs1 = iw.r_fmt.rs1;
    assign rs2 = iw.r_fmt.rs2;
    assign rd  = iw.r_fmt.rd;

    assign imm_i = {{20{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
    assign imm_s = {{20{iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi, iw.s_fmt.imm_lo};
    assign imm_u = {iw.u_fmt.imm, 12'b0};
    assign imm_j = {{11{iw.j_fmt.imm_20}}, iw.j_fmt.imm_20, iw.j_fmt.imm_19_12,
                    iw.j_fmt.imm_11, iw.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        valid = 1'b1;
        wen   = 1'b1;
        ren   = 2'b01;
        arg   = core_pkg::arg_rs1_imm;
        alu   = core_pkg::alu_add;
        pcs   = core_pkg::pc_seq;
        mem   = core_pkg::mem_none;
        shamt = 1'b0;
        uns   = 1'b0;
        halt  = 1'b0;
        imm   = imm_i;
        case (iw.r_fmt.opcode)
            core_pkg::op_lui: begin
                ren = 2'b00;
                arg = core_pkg::arg_zero_imm;
                imm = imm_u;
            end
            core_pkg::op_auipc: begin
                ren = 2'b00;
                arg = core_pkg::arg_pc_imm;
                imm = imm_u;
            end
            core_pkg::op_jal: begin
                ren = 2'b00;
                arg = core_pkg::arg_pc_imm;
                alu = core_pkg::alu_link;
                pcs = core_pkg::pc_rel;
                imm = imm_j;
            end
            core_pkg::op_jalr: begin
                alu   = core_pkg::alu_link;
                pcs   = core_pkg::pc_reg;
                valid = (f3 == 3'b000);
            end
            core_pkg::op_load: begin
                // lbu/lhu reuse lb/lh with uns
                mem   = {1'b1, f3[1:0] + 2'b01};
                uns   = f3[2];
                valid = (f3[1:0] != 2'b11) && !(f3[2] && f3[1]);
            end
            core_pkg::op_store: begin
                wen   = 1'b0;
                ren   = 2'b11;
                imm   = imm_s;
                mem   = {1'b0, f3[1:0] + 2'b01};
                valid = (f3[2] == 1'b0) && (f3[1:0] != 2'b11);
            end
            core_pkg::op_imm, core_pkg::op_reg: begin
                if (iw.r_fmt.opcode == core_pkg::op_reg) begin
                    ren = 2'b11;
                    arg = core_pkg::arg_rs1_rs2;
                end
                // shamt from imm only for the immediate forms
                shamt = (f3[1:0] == 2'b01) && (iw.r_fmt.opcode == core_pkg::op_imm);
                case (f3)
                    3'b000: alu = core_pkg::alu_add;
                    3'b100: alu = core_pkg::alu_xor;
                    3'b110: alu = core_pkg::alu_or;
                    3'b111: alu = core_pkg::alu_and;
                    3'b001: alu = core_pkg::alu_shl;
                    3'b101: alu = core_pkg::alu_shr;
                    default: valid = 1'b0;
                endcase
                // srl/srli logical, sra/srai arithmetic
                uns = (f3 == 3'b101) && !f7[5];
                // funct7 only free for immediates, except bit 5 on right shifts
                if ((iw.r_fmt.opcode == core_pkg::op_reg || f3[1:0] == 2'b01) &&
                    (f7 & {1'b1, f3 != 3'b101, 5'b11111}) != 7'b0) begin
                    valid = 1'b0;
                end
            end
            core_pkg::op_system: begin
                wen   = 1'b0;
                ren   = 2'b00;
                alu   = core_pkg::alu_none;
                pcs   = core_pkg::pc_hold;
                halt  = 1'b1;
                valid = (inst == core_pkg::ebreak_word);
            end
            default: valid = 1'b0;
        endcase
    end

    // unknown encodings pack to an all-zero word
    always_comb begin
        opt = '0;
        if (valid) begin
            opt[core_pkg::opt_wen] = wen;
            opt[core_pkg::opt_ren_hi:core_pkg::opt_ren_lo] = ren;
            opt[core_pkg::opt_arg_hi:core_pkg::opt_arg_lo] = arg;
            opt[core_pkg::opt_alu_hi:core_pkg::opt_alu_lo] = alu;
            opt[core_pkg::opt_pc_hi:core_pkg::opt_pc_lo]   = pcs;
            opt[core_pkg::opt_mem_hi:core_pkg::opt_mem_lo] = mem;
            opt[core_pkg::opt_shamt] = shamt;
            opt[core_pkg::opt_uns]   = uns;
            opt[core_pkg::opt_halt]  = halt;
        end
    end

endmodule

`default_nettype wire

/* design/reg_file.sv */
/*
 * integer register file
 *   32 x 32, x0 reads as zero
 *   two combinational reads, one write
 */
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        wen,
    input  logic [1:0]  ren,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    // writes to x0 are dropped
    always_ff @(posedge clk) begin
        if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // ren[0] for rs1, ren[1] for rs2
    assign rdata1 = (ren[0] && raddr1 != 5'd0) ? regs[raddr1] : 32'd0;
    assign rdata2 = (ren[1] && raddr2 != 5'd0) ? regs[raddr2] : 32'd0;

    // written data is never undefined
    a_wdata_known: assert property (@(posedge clk) wen |-> !$isunknown(wdata));

endmodule

`default_nettype wire

/* execute/exec_unit.sv */
/*
 * execute stage
 *   operand select and alu
 *   next pc and load/store address
 *   writeback select between alu and load data
 */
`default_nettype none

module exec_unit (
    input  logic [core_pkg::opt_w-1:0] opt,
    input  logic [31:0]               rs1_d,
    input  logic [31:0]               rs2_d,
    input  logic [31:0]               imm,
    input  logic [31:0]               pc,
    input  logic [31:0]               load_d,
    output logic [31:0]               rd_d,
    output logic [31:0]               dnpc,
    output logic [31:0]               mem_addr
);

    logic [1:0]  arg;
    logic [2:0]  alu;
    logic [1:0]  pcs;
    logic [31:0] op_a, op_b;
    logic [31:0] alu_y;
    logic [31:0] pc_4;
    logic [4:0]  sh;

    assign arg  = opt[core_pkg::opt_arg_hi:core_pkg::opt_arg_lo];
    assign alu  = opt[core_pkg::opt_alu_hi:core_pkg::opt_alu_lo];
    assign pcs  = opt[core_pkg::opt_pc_hi:core_pkg::opt_pc_lo];
    assign pc_4 = pc + 32'd4;

    always_comb begin
        case (arg)
            core_pkg::arg_zero_imm: op_a = 32'd0;
            core_pkg::arg_pc_imm:   op_a = pc;
            default:                op_a = rs1_d;
        endcase
        op_b = (arg == core_pkg::arg_rs1_rs2) ? rs2_d : imm;
    end

    // immediate shifts take shamt from imm
    assign sh = opt[core_pkg::opt_shamt] ? imm[4:0] : rs2_d[4:0];

    always_comb begin
        case (alu)
            core_pkg::alu_add:  alu_y = op_a + op_b;
            core_pkg::alu_and:  alu_y = op_a & op_b;
            core_pkg::alu_or:   alu_y = op_a | op_b;
            core_pkg::alu_xor:  alu_y = op_a ^ op_b;
            core_pkg::alu_shl:  alu_y = op_a << sh;
            core_pkg::alu_shr: begin
                if (opt[core_pkg::opt_uns]) begin
                    alu_y = op_a >> sh;
                end else begin
                    alu_y = $signed(op_a) >>> sh;
                end
            end
            // return address of jal/jalr
            core_pkg::alu_link: alu_y = pc_4;
            default:            alu_y = 32'd0;
        endcase
    end

    always_comb begin
        case (pcs)
            core_pkg::pc_hold: dnpc = pc;
            core_pkg::pc_rel:  dnpc = pc + imm;
            // jalr target, bit 0 cleared
            core_pkg::pc_reg:  dnpc = (rs1_d + imm) & ~32'd1;
            default:           dnpc = pc_4;
        endcase
    end

    assign mem_addr = rs1_d + imm;

    // load codes have the top mem bit set
    assign rd_d = opt[core_pkg::opt_mem_hi] ? load_d : alu_y;

endmodule

`default_nettype wire

/* design/data_mem.sv */
/*
 * data memory
 *   byte array, little endian
 *   sized stores, sign or zero extended loads
 */
`default_nettype none

module data_mem (
    input  logic                        clk,
    input  logic [2:0]                  mem_op,
    input  logic                        uns,
    input  logic                        halted,
    input  logic [core_pkg::dmem_aw-1:0] addr,
    input  logic [31:0]                 wdata,
    output logic [31:0]                 rdata
);

    logic [7:0]                  mem [2**core_pkg::dmem_aw];
    logic [core_pkg::dmem_aw-1:0] a1, a2, a3;
    logic [7:0]                  b0, b1, b2, b3;

    // byte lanes of the access
    assign a1 = addr + 1'b1;
    assign a2 = addr + 2'd2;
    assign a3 = addr + 2'd3;

    // stores commit at the edge unless halted
    always_ff @(posedge clk) begin
        if (!halted) begin
            case (mem_op)
                core_pkg::mem_sb: mem[addr] <= wdata[7:0];
                core_pkg::mem_sh: begin
                    mem[addr] <= wdata[7:0];
                    mem[a1]   <= wdata[15:8];
                end
                core_pkg::mem_sw: begin
                    mem[addr] <= wdata[7:0];
                    mem[a1]   <= wdata[15:8];
                    mem[a2]   <= wdata[23:16];
                    mem[a3]   <= wdata[31:24];
                end
                default: ;
            endcase
        end
    end

    assign b0 = mem[addr];
    assign b1 = mem[a1];
    assign b2 = mem[a2];
    assign b3 = mem[a3];

    // uns turns lb/lh into lbu/lhu
    always_comb begin
        case (mem_op)
            core_pkg::mem_lb: rdata = {{24{~uns & b0[7]}}, b0};
            core_pkg::mem_lh: rdata = {{16{~uns & b1[7]}}, b1, b0};
            core_pkg::mem_lw: rdata = {b3, b2, b1, b0};
            default:          rdata = 32'd0;
        endcase
    end

    // decode plus exec address must land naturally aligned
    a_half_align: assert property (@(posedge clk) disable iff (halted)
        (mem_op == core_pkg::mem_sh || mem_op == core_pkg::mem_lh) |-> !addr[0]);

    a_word_align: assert property (@(posedge clk) disable iff (halted)
        (mem_op == core_pkg::mem_sw || mem_op == core_pkg::mem_lw) |-> addr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* design/cpu_top.sv */
/*
 * single cycle rv32i subset core
 *   fetch, decode, register file, execute, data memory
 *   program load port and retire view
 */
`default_nettype none

module cpu_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        prog_we,
    input  logic [core_pkg::imem_aw-1:0] prog_addr,
    input  logic [31:0]                 prog_data,
    output logic [31:0]                 pc,
    output logic [31:0]                 inst,
    output logic                        halted,
    output logic                        wb_en,
    output logic [4:0]                  wb_addr,
    output logic [31:0]                 wb_data
);

    logic [4:0]                rs1, rs2;
    logic [31:0]               imm;
    logic [core_pkg::opt_w-1:0] opt;
    logic [31:0]               rs1_d, rs2_d;
    logic [31:0]               dnpc, mem_addr, load_d;

    fetch_unit u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .dnpc      (dnpc),
        .halt_req  (opt[core_pkg::opt_halt]),
        .pc        (pc),
        .inst      (inst),
        .halted    (halted)
    );

    inst_decoder u_dec (
        .inst (inst),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (wb_addr),
        .imm  (imm),
        .opt  (opt)
    );

    // halted carries the reset mask as well
    assign wb_en = opt[core_pkg::opt_wen] & ~halted;

    reg_file u_rf (
        .clk    (clk),
        .wen    (wb_en),
        .ren    (opt[core_pkg::opt_ren_hi:core_pkg::opt_ren_lo]),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_d),
        .rdata2 (rs2_d)
    );

    exec_unit u_exu (
        .opt      (opt),
        .rs1_d    (rs1_d),
        .rs2_d    (rs2_d),
        .imm      (imm),
        .pc       (pc),
        .load_d   (load_d),
        .rd_d     (wb_data),
        .dnpc     (dnpc),
        .mem_addr (mem_addr)
    );

    // data ram sits at address 0, low bits only
    data_mem u_dmem (
        .clk    (clk),
        .mem_op (opt[core_pkg::opt_mem_hi:core_pkg::opt_mem_lo]),
        .uns    (opt[core_pkg::opt_uns]),
        .halted (halted),
        .addr   (mem_addr[core_pkg::dmem_aw-1:0]),
        .wdata  (rs2_d),
        .rdata  (load_d)
    );

endmodule

`default_nettype wire

/* sim/cpu_tb.sv */
/*
 * testbench for the single cycle core
 *   random program generator and instruction encoders
 *   reference model of pc, registers and data bytes
 *   per cycle compare, value check and watchdog
 */
`default_nettype none

module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_progs = 20;
    localparam int body_len = 110;
    localparam logic [31:0] reset_pc = 32'h8000_0000;
    localparam logic [6:0] o_lui = 7'h37, o_auipc = 7'h17, o_jal = 7'h6f, o_jalr = 7'h67;
    localparam logic [6:0] o_load = 7'h03, o_store = 7'h23, o_imm = 7'h13, o_reg = 7'h33;

    logic clk = 1'b0;
    logic rst_n, prog_we;
    logic [7:0] prog_addr;
    logic [31:0] prog_data, pc, inst, wb_data;
    logic halted, wb_en;
    logic [4:0] wb_addr;

    // program image and reference state
    logic [31:0] prog_mem [256];
    int prog_len;
    logic [31:0] m_pc;
    logic [31:0] m_regs [32];
    logic [7:0] m_mem [1024];
    logic m_halted, active, prog_done;
    int held_cycles;
    logic e_en;
    logic [4:0] e_addr;
    logic [31:0] e_data;

    cpu_top dut0 (
        .clk(clk), .rst_n(rst_n), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .pc(pc), .inst(inst), .halted(halted),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
    );

    always #50 clk = ~clk;

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // instruction encoders
    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], o_store};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, o_jal};
    endfunction

    // one of add, xor, or, and, sll, srl/sra
    function automatic logic [2:0] pick_alu_f3();
        logic [2:0] tbl [6];
        tbl = '{3'd0, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5};
        return tbl[$urandom % 6];
    endfunction

    task automatic gen_program();
        int i, k, kind, base, ebreak_idx;
        logic [4:0] rd, rs1, rx;
        logic [2:0] f3;
        logic [6:0] f7;
        bit is_target [256];
        is_target = '{default: 1'b0};
        base = int'($urandom % 16) * 64;
        prog_len = 31 + 16 + body_len + 1;
        ebreak_idx = prog_len - 1;
        // every register gets a value first
        for (i = 1; i < 32; i++) begin
            prog_mem[i - 1] = enc_i(12'($urandom), 5'd0, 3'd0, 5'(i), o_imm);
        end
        // then the 64 byte data window, so loads never see unwritten bytes
        for (i = 0; i < 16; i++) begin
            prog_mem[31 + i] = enc_s(12'(base + 4 * i), 5'(1 + $urandom % 31), 3'd2);
        end
        i = 47;
        while (i < ebreak_idx) begin
            kind = int'($urandom % 10);
            rd = 5'($urandom);
            rs1 = 5'($urandom);
            case (kind)
                0: prog_mem[i] = {20'($urandom), rd, o_lui};
                1: prog_mem[i] = {20'($urandom), rd, o_auipc};
                2, 3: begin
                    f3 = pick_alu_f3();
                    f7 = (f3 == 3'd5 && $urandom % 2 == 1) ? 7'h20 : 7'h00;
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        prog_mem[i] = enc_i({f7, 5'($urandom)}, rs1, f3, rd, o_imm);
                    end else begin
                        prog_mem[i] = enc_i(12'($urandom), rs1, f3, rd, o_imm);
                    end
                end
                4, 5: begin
                    f3 = pick_alu_f3();
                    f7 = (f3 == 3'd5 && $urandom % 2 == 1) ? 7'h20 : 7'h00;
                    prog_mem[i] = {f7, 5'($urandom), rs1, f3, rd, o_reg};
                end
                6: begin
                    // sb, sh or sw, naturally aligned in the window
                    f3 = 3'($urandom % 3);
                    k = base + int'($urandom % 64) & ~((1 << f3) - 1);
                    prog_mem[i] = enc_s(12'(k), 5'($urandom), f3);
                end
                7: begin
                    f3 = 3'($urandom % 5);
                    if (f3 == 3'd3) f3 = 3'd4;
                    if (f3 == 3'd2 && $urandom % 2 == 1) f3 = 3'd5;
                    k = base + int'($urandom % 64) & ~((1 << f3[1:0]) - 1);
                    prog_mem[i] = enc_i(12'(k), 5'd0, f3, rd, o_load);
                end
                8: begin
                    k = int'($urandom % 4);
                    if (k > ebreak_idx - i - 1) k = ebreak_idx - i - 1;
                    prog_mem[i] = enc_j(21'(4 * (k + 1)), rd);
                    is_target[i + 1 + k] = 1'b1;
                end
                default: begin
                    // auipc then jalr, never entered in the middle
                    if (i + 1 < ebreak_idx && !is_target[i + 1]) begin
                        k = int'($urandom % 4);
                        if (k > ebreak_idx - i - 2) k = ebreak_idx - i - 2;
                        rx = 5'(1 + $urandom % 31);
                        prog_mem[i] = {20'd0, rx, o_auipc};
                        // odd offsets check that bit 0 is cleared
                        prog_mem[i + 1] = enc_i(12'(8 + 4 * k + $urandom % 2), rx, 3'd0, rd,
                                                o_jalr);
                        is_target[i + 2 + k] = 1'b1;
                        i++;
                    end else begin
                        prog_mem[i] = enc_i(12'($urandom), rs1, 3'd0, rd, o_imm);
                    end
                end
            endcase
            i++;
        end
        prog_mem[ebreak_idx] = 32'h0010_0073;
    endtask

    // architectural step from the rv32i rules
    function automatic void iss_step(input logic [31:0] iw, output logic en,
                                     output logic [4:0] rd, output logic [31:0] val);
        logic [31:0] rs1v, rs2v, imm_i, imm_s, imm_u, imm_j, b, npc;
        logic [9:0] a;
        logic [2:0] f3;
        rd = iw[11:7];
        f3 = iw[14:12];
        rs1v = m_regs[iw[19:15]];
        rs2v = m_regs[iw[24:20]];
        imm_i = {{20{iw[31]}}, iw[31:20]};
        imm_s = {{20{iw[31]}}, iw[31:25], iw[11:7]};
        imm_u = {iw[31:12], 12'd0};
        imm_j = {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
        en = 1'b1;
        val = 32'd0;
        npc = m_pc + 32'd4;
        case (iw[6:0])
            o_lui: val = imm_u;
            o_auipc: val = m_pc + imm_u;
            o_jal: begin
                val = m_pc + 32'd4;
                npc = m_pc + imm_j;
            end
            o_jalr: begin
                val = m_pc + 32'd4;
                npc = (rs1v + imm_i) & 32'hffff_fffe;
            end
            o_imm, o_reg: begin
                b = (iw[6:0] == o_imm) ? imm_i : rs2v;
                case (f3)
                    3'd0: val = rs1v + b;
                    3'd4: val = rs1v ^ b;
                    3'd6: val = rs1v | b;
                    3'd7: val = rs1v & b;
                    3'd1: val = rs1v << b[4:0];
                    default: val = iw[30] ? 32'($signed(rs1v) >>> b[4:0]) : rs1v >> b[4:0];
                endcase
            end
            o_load: begin
                a = 10'(rs1v + imm_i);
                case (f3)
                    3'd0: val = {{24{m_mem[a][7]}}, m_mem[a]};
                    3'd1: val = {{16{m_mem[a + 10'd1][7]}}, m_mem[a + 10'd1], m_mem[a]};
                    3'd2: val = {m_mem[a + 10'd3], m_mem[a + 10'd2], m_mem[a + 10'd1], m_mem[a]};
                    3'd4: val = {24'd0, m_mem[a]};
                    default: val = {16'd0, m_mem[a + 10'd1], m_mem[a]};
                endcase
            end
            o_store: begin
                en = 1'b0;
                a = 10'(rs1v + imm_s);
                m_mem[a] = rs2v[7:0];
                if (f3 != 3'd0) m_mem[a + 10'd1] = rs2v[15:8];
                if (f3 == 3'd2) begin
                    m_mem[a + 10'd2] = rs2v[23:16];
                    m_mem[a + 10'd3] = rs2v[31:24];
                end
            end
            default: begin
                // ebreak, the only system op generated
                en = 1'b0;
                npc = m_pc;
                m_halted = 1'b1;
            end
        endcase
        if (en && rd != 5'd0) m_regs[rd] = val;
        m_pc = npc;
    endfunction

    task automatic load_and_reset();
        int i;
        @(negedge clk);
        rst_n = 1'b0;
        for (i = 0; i < prog_len; i++) begin
            @(negedge clk);
            prog_we = 1'b1;
            prog_addr = 8'(i);
            prog_data = prog_mem[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
        // three cycles of plain reset after the load
        repeat (3) @(negedge clk);
        #40;
        check("pc", reset_pc, pc);
        check("wb_en", 32'd0, 32'(wb_en));
        @(negedge clk);
        rst_n = 1'b1;
        m_pc = reset_pc;
        m_halted = 1'b0;
        held_cycles = 0;
        active = 1'b1;
    endtask

    // compare shortly before each rising edge
    always @(negedge clk) begin
        #40;
        if (active) begin
            check("pc", m_pc, pc);
            check("inst", prog_mem[(m_pc - reset_pc) >> 2], inst);
            check("halted", 32'(m_halted), 32'(halted));
            if (m_halted) begin
                check("wb_en", 32'd0, 32'(wb_en));
                held_cycles++;
                if (held_cycles == 10) begin
                    active = 1'b0;
                    prog_done = 1'b1;
                end
            end else begin
                iss_step(prog_mem[(m_pc - reset_pc) >> 2], e_en, e_addr, e_data);
                check("wb_en", 32'(e_en), 32'(wb_en));
                if (e_en) begin
                    check("wb_addr", 32'(e_addr), 32'(wb_addr));
                    check("wb_data", e_data, wb_data);
                end
            end
        end
    end

    initial begin
        #(n_progs * 400 * 100);
        $display("timeout: the programs did not all finish in time");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int p, j;
        rst_n = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        active = 1'b0;
        prog_done = 1'b0;
        m_halted = 1'b0;
        for (j = 0; j < 32; j++) m_regs[j] = 32'd0;
        for (j = 0; j < 1024; j++) m_mem[j] = 8'd0;
        void'($urandom(32'h4510_bb92));
        for (p = 0; p < n_progs; p++) begin
            gen_program();
            load_and_reset();
            wait (prog_done);
            prog_done = 1'b0;
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
common/core_pkg.sv
fetch/fetch_unit.sv
decode/inst_decoder.sv
design/reg_file.sv
execute/exec_unit.sv
design/data_mem.sv
design/cpu_top.sv
sim/cpu_tb.sv
